/* source/mem_geometry_pkg.sv */
`default_nettype none

package mem_geometry_pkg;

  localparam int WORD_WIDTH   = 16;
  localparam int NUM_WR_PORTS = 2;
  localparam int NUM_RD_PORTS = 2;

  localparam int NUM_BANKS = 8;
  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int BANK_ROWS = 16;
  localparam int ROW_BITS  = $clog2(BANK_ROWS);
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [BANK_BITS-1:0]  bank_t;
  typedef logic [ROW_BITS-1:0]   row_t;

  // Bank in the upper bits, row in the lower bits
  typedef struct packed {
    bank_t bank;
    row_t  row;
  } phys_addr_fields_t;

  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    phys_addr_fields_t    fields;
  } phys_addr_u;

endpackage

`default_nettype wire

/* source/mem_timing_pkg.sv */
`default_nettype none

package mem_timing_pkg;

  import mem_geometry_pkg::*;

  // A chain register sits after every group of this many banks
  localparam int BANKS_PER_STAGE = 4;
  localparam int NUM_STAGES      = NUM_BANKS / BANKS_PER_STAGE;

  localparam int SRAM_DELAY = 1;

  // Command register, one register per stage, bank read
  localparam int READ_LATENCY = NUM_STAGES + SRAM_DELAY + 1;

endpackage

`default_nettype wire

/* source/bank_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bank_cmd_if
  import mem_geometry_pkg::*, mem_timing_pkg::*;
  ();

  // Bank signals are grouped as [stage][bank within stage]
  // and already carry the delay of their stage
  logic [NUM_STAGES-1:0][BANKS_PER_STAGE-1:0] wr_en;
  row_t [NUM_STAGES-1:0][BANKS_PER_STAGE-1:0] wr_row;
  logic [NUM_STAGES-1:0][BANKS_PER_STAGE-1:0] rd_en;
  row_t [NUM_STAGES-1:0][BANKS_PER_STAGE-1:0] rd_row;

  // Which write port feeds a bank
  logic [NUM_STAGES-1:0][BANKS_PER_STAGE-1:0][NUM_WR_PORTS-1:0] wr_sel;

  // Which bank feeds a read port, aligned with the bank read data
  logic [NUM_RD_PORTS-1:0][NUM_STAGES-1:0][BANKS_PER_STAGE-1:0] rd_sel;

  modport ctrl (output wr_en, wr_row, rd_en, rd_row, wr_sel, rd_sel);

  modport ram (input wr_en, wr_row, rd_en, rd_row);

  modport wdata (input wr_sel);

  modport rdata (input rd_sel);

endinterface

`default_nettype wire

/* source/bank_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_cmd_ctrl
  import mem_geometry_pkg::*, mem_timing_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [NUM_WR_PORTS-1:0]  wr_en,
  input  wire bank_t [NUM_WR_PORTS-1:0] wr_bank,
  input  wire row_t [NUM_WR_PORTS-1:0]  wr_row,
  input  wire logic [NUM_RD_PORTS-1:0]  rd_en,
  input  wire bank_t [NUM_RD_PORTS-1:0] rd_bank,
  input  wire row_t [NUM_RD_PORTS-1:0]  rd_row,
  bank_cmd_if.ctrl                      cmd,
  output logic [NUM_RD_PORTS-1:0]       rd_vld,
  output phys_addr_u [NUM_RD_PORTS-1:0] rd_addr
);

  logic [NUM_BANKS-1:0][NUM_WR_PORTS-1:0] wr_sel_dec;
  logic [NUM_BANKS-1:0][NUM_RD_PORTS-1:0] rd_sel_dec;
  logic [NUM_BANKS-1:0]                   wr_en_dec;
  logic [NUM_BANKS-1:0]                   rd_en_dec;
  row_t [NUM_BANKS-1:0]                   wr_row_dec;
  row_t [NUM_BANKS-1:0]                   rd_row_dec;
  phys_addr_u [NUM_RD_PORTS-1:0]          rd_tag;

  // Index d holds the command d cycles after the first register
  logic [NUM_STAGES-1:0][NUM_BANKS-1:0]                   wr_en_q;
  logic [NUM_STAGES-1:0][NUM_BANKS-1:0][NUM_WR_PORTS-1:0] wr_sel_q;
  row_t [NUM_STAGES-1:0][NUM_BANKS-1:0]                   wr_row_q;
  logic [NUM_STAGES-1:0][NUM_BANKS-1:0]                   rd_en_q;
  row_t [NUM_STAGES-1:0][NUM_BANKS-1:0]                   rd_row_q;
  logic [NUM_STAGES+SRAM_DELAY-1:0][NUM_BANKS-1:0][NUM_RD_PORTS-1:0] rd_sel_q;

  logic [READ_LATENCY-1:0][NUM_RD_PORTS-1:0]       vld_q;
  phys_addr_u [READ_LATENCY-1:0][NUM_RD_PORTS-1:0] tag_q;

  always_comb begin
    wr_sel_dec = '0;
    rd_sel_dec = '0;
    wr_row_dec = '0;
    rd_row_dec = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int p = 0; p < NUM_WR_PORTS; p++) begin
        if (wr_en[p] && wr_bank[p] == bank_t'(b)) begin
          wr_sel_dec[b][p] = 1'b1;
          wr_row_dec[b]    = wr_row[p];
        end
      end
      for (int p = 0; p < NUM_RD_PORTS; p++) begin
        if (rd_en[p] && rd_bank[p] == bank_t'(b)) begin
          rd_sel_dec[b][p] = 1'b1;
          rd_row_dec[b]    = rd_row[p];
        end
      end
      wr_en_dec[b] = |wr_sel_dec[b];
      rd_en_dec[b] = |rd_sel_dec[b];
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_tag[p].fields.bank = rd_bank[p];
      rd_tag[p].fields.row  = rd_row[p];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_q  <= '0;
      wr_sel_q <= '0;
      rd_en_q  <= '0;
      rd_sel_q <= '0;
      vld_q    <= '0;
    end else begin
      wr_en_q[0]  <= wr_en_dec;
      wr_sel_q[0] <= wr_sel_dec;
      rd_en_q[0]  <= rd_en_dec;
      for (int d = 1; d < NUM_STAGES; d++) begin
        wr_en_q[d]  <= wr_en_q[d-1];
        wr_sel_q[d] <= wr_sel_q[d-1];
        rd_en_q[d]  <= rd_en_q[d-1];
      end
      rd_sel_q[0] <= rd_sel_dec;
      for (int d = 1; d < NUM_STAGES + SRAM_DELAY; d++) begin
        rd_sel_q[d] <= rd_sel_q[d-1];
      end
      vld_q[0] <= rd_en;
      for (int d = 1; d < READ_LATENCY; d++) begin
        vld_q[d] <= vld_q[d-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_row_q[0] <= wr_row_dec;
    rd_row_q[0] <= rd_row_dec;
    for (int d = 1; d < NUM_STAGES; d++) begin
      wr_row_q[d] <= wr_row_q[d-1];
      rd_row_q[d] <= rd_row_q[d-1];
    end
    tag_q[0] <= rd_tag;
    for (int d = 1; d < READ_LATENCY; d++) begin
      tag_q[d] <= tag_q[d-1];
    end
  end

  // Each bank takes the copy delayed by its own stage number
  always_comb begin
    for (int s = 0; s < NUM_STAGES; s++) begin
      for (int k = 0; k < BANKS_PER_STAGE; k++) begin
        cmd.wr_en[s][k]  = wr_en_q[s][s*BANKS_PER_STAGE + k];
        cmd.wr_row[s][k] = wr_row_q[s][s*BANKS_PER_STAGE + k];
        cmd.wr_sel[s][k] = wr_sel_q[s][s*BANKS_PER_STAGE + k];
        cmd.rd_en[s][k]  = rd_en_q[s][s*BANKS_PER_STAGE + k];
        cmd.rd_row[s][k] = rd_row_q[s][s*BANKS_PER_STAGE + k];
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
          cmd.rd_sel[p][s][k] = rd_sel_q[s+SRAM_DELAY][s*BANKS_PER_STAGE + k][p];
        end
      end
    end
  end

  assign rd_vld  = vld_q[READ_LATENCY-1];
  assign rd_addr = tag_q[READ_LATENCY-1];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_port_excl
    a_wr_one_port: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(wr_sel_dec[b]))
      else $error("two write ports address bank %0d in one cycle", b);
    a_rd_one_port: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(rd_sel_dec[b]))
      else $error("two read ports address bank %0d in one cycle", b);
  end

endmodule

`default_nettype wire

/* source/write_data_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module write_data_chain
  import mem_geometry_pkg::*, mem_timing_pkg::*;
(
  input  wire logic                     clk,
  input  wire word_t [NUM_WR_PORTS-1:0] wr_data,
  bank_cmd_if.wdata                     cmd,
  output word_t [NUM_BANKS-1:0]         bank_wdata
);

  // Port data as it passes the banks of each stage
  word_t [NUM_STAGES-1:0][NUM_WR_PORTS-1:0] stage_data;

  // Entry register, then one register behind the last bank of a stage
  always_ff @(posedge clk) begin
    stage_data[0] <= wr_data;
    for (int s = 1; s < NUM_STAGES; s++) begin
      stage_data[s] <= stage_data[s-1];
    end
  end

  // At most one port selects a bank, so the first match is the only one
  always_comb begin
    bank_wdata = '0;
    for (int s = 0; s < NUM_STAGES; s++) begin
      for (int k = 0; k < BANKS_PER_STAGE; k++) begin
        for (int p = 0; p < NUM_WR_PORTS; p++) begin
          if (cmd.wr_sel[s][k][p]) begin
            bank_wdata[s*BANKS_PER_STAGE + k] = stage_data[s][p];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_ram
  import mem_geometry_pkg::*, mem_timing_pkg::*;
(
  input  wire logic                  clk,
  bank_cmd_if.ram                    cmd,
  input  wire word_t [NUM_BANKS-1:0] bank_wdata,
  output wire word_t [NUM_BANKS-1:0] bank_rdata
);

  for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
    for (genvar k = 0; k < BANKS_PER_STAGE; k++) begin : g_bank
      word_t rows [BANK_ROWS];
      word_t rdata_q;

      // Read sees the row before this cycle's write
      always_ff @(posedge clk) begin
        if (cmd.wr_en[s][k]) begin
          rows[cmd.wr_row[s][k]] <= bank_wdata[s*BANKS_PER_STAGE + k];
        end
        if (cmd.rd_en[s][k]) begin
          rdata_q <= rows[cmd.rd_row[s][k]];
        end
      end

      assign bank_rdata[s*BANKS_PER_STAGE + k] = rdata_q;

      a_wr_row_known: assert property (@(posedge clk)
        cmd.wr_en[s][k] |-> !$isunknown(cmd.wr_row[s][k]))
        else $error("bank %0d written at an unknown row", s*BANKS_PER_STAGE + k);
    end
  end

endmodule

`default_nettype wire

/* source/read_data_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module read_data_chain
  import mem_geometry_pkg::*, mem_timing_pkg::*;
(
  input  wire logic                  clk,
  input  wire word_t [NUM_BANKS-1:0] bank_rdata,
  bank_cmd_if.rdata                  cmd,
  output word_t [NUM_RD_PORTS-1:0]   rd_data
);

  // Word leaving each stage, and the register behind it
  word_t [NUM_RD_PORTS-1:0][NUM_STAGES-1:0] stage_out;
  word_t [NUM_RD_PORTS-1:0][NUM_STAGES-1:0] stage_q;

  always_comb begin : chain_mux
    word_t link;
    link = '0;
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      for (int s = 0; s < NUM_STAGES; s++) begin
        // Chain starts empty at the first bank
        if (s == 0) begin
          link = '0;
        end else begin
          link = stage_q[p][s-1];
        end
        for (int k = 0; k < BANKS_PER_STAGE; k++) begin
          if (cmd.rd_sel[p][s][k]) begin
            link = bank_rdata[s*BANKS_PER_STAGE + k];
          end
        end
        stage_out[p][s] = link;
      end
    end
  end

  always_ff @(posedge clk) begin
    stage_q <= stage_out;
  end

  // Last register levels out the latency of early and late banks
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_data[p] = stage_q[p][NUM_STAGES-1];
    end
  end

endmodule

`default_nettype wire

/* source/banked_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_top
  import mem_geometry_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [NUM_WR_PORTS-1:0]  wr_en,
  input  wire bank_t [NUM_WR_PORTS-1:0] wr_bank,
  input  wire row_t [NUM_WR_PORTS-1:0]  wr_row,
  input  wire word_t [NUM_WR_PORTS-1:0] wr_data,
  input  wire logic [NUM_RD_PORTS-1:0]  rd_en,
  input  wire bank_t [NUM_RD_PORTS-1:0] rd_bank,
  input  wire row_t [NUM_RD_PORTS-1:0]  rd_row,
  output logic [NUM_RD_PORTS-1:0]       rd_vld,
  output logic [NUM_RD_PORTS-1:0][ADDR_BITS-1:0] rd_addr,
  output word_t [NUM_RD_PORTS-1:0]      rd_data
);

  phys_addr_u [NUM_RD_PORTS-1:0] rd_tag;
  word_t [NUM_BANKS-1:0]         bank_wdata;
  word_t [NUM_BANKS-1:0]         bank_rdata;

  bank_cmd_if cmd_i ();

  bank_cmd_ctrl ctrl_i (
    .clk,
    .rst_n,
    .wr_en,
    .wr_bank,
    .wr_row,
    .rd_en,
    .rd_bank,
    .rd_row,
    .cmd     (cmd_i.ctrl),
    .rd_vld,
    .rd_addr (rd_tag)
  );

  write_data_chain wdata_i (
    .clk,
    .wr_data,
    .cmd        (cmd_i.wdata),
    .bank_wdata
  );

  bank_ram ram_i (
    .clk,
    .cmd        (cmd_i.ram),
    .bank_wdata,
    .bank_rdata
  );

  read_data_chain rdata_i (
    .clk,
    .bank_rdata,
    .cmd        (cmd_i.rdata),
    .rd_data
  );

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_addr[p] = rd_tag[p].flat;
    end
  end

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk
);

  // 40 ns period
  localparam realtime HALF_PERIOD = 20ns;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

`default_nettype wire

/* bench/banked_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_tb
  import mem_geometry_pkg::*, mem_timing_pkg::*;
();

  localparam int          MAX_OPS      = 64;
  localparam int          NUM_FIELDS   = 4 * NUM_WR_PORTS + 3 * NUM_RD_PORTS;
  localparam int          RESET_CYCLES = 16;
  localparam int          MARGIN       = 20;
  localparam logic [31:0] UNUSED       = 32'hffff_ffff;

  typedef struct packed {
    int                   due;
    int                   port;
    logic [ADDR_BITS-1:0] addr;
    word_t                data;
  } exp_read_t;

  logic                                   clk;
  logic                                   rst_n;
  logic [NUM_WR_PORTS-1:0]                wr_en;
  bank_t [NUM_WR_PORTS-1:0]               wr_bank;
  row_t [NUM_WR_PORTS-1:0]                wr_row;
  word_t [NUM_WR_PORTS-1:0]               wr_data;
  logic [NUM_RD_PORTS-1:0]                rd_en;
  bank_t [NUM_RD_PORTS-1:0]               rd_bank;
  row_t [NUM_RD_PORTS-1:0]                rd_row;
  logic [NUM_RD_PORTS-1:0]                rd_vld;
  logic [NUM_RD_PORTS-1:0][ADDR_BITS-1:0] rd_addr;
  word_t [NUM_RD_PORTS-1:0]               rd_data;

  logic [31:0] op_fields [MAX_OPS*NUM_FIELDS];
  word_t       ref_mem [NUM_BANKS*BANK_ROWS];
  exp_read_t   exp_q [$];
  int          num_ops;
  int unsigned check_count   = 0;
  int unsigned error_count   = 0;
  int unsigned cycle_count   = 0;
  int unsigned timeout_limit = 0;

  clk_gen clk_gen_i (.clk);

  banked_mem_top dut_i (
    .clk,
    .rst_n,
    .wr_en,
    .wr_bank,
    .wr_row,
    .wr_data,
    .rd_en,
    .rd_bank,
    .rd_row,
    .rd_vld,
    .rd_addr,
    .rd_data
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Disabled ports carry random bank, row and data
  task automatic drive_idle();
    wr_en = '0;
    rd_en = '0;
    for (int p = 0; p < NUM_WR_PORTS; p++) begin
      wr_bank[p] = bank_t'($urandom());
      wr_row[p]  = row_t'($urandom());
      wr_data[p] = word_t'($urandom());
    end
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_bank[p] = bank_t'($urandom());
      rd_row[p]  = row_t'($urandom());
    end
  endtask

  task automatic apply_op(input int i, input int n);
    int        f;
    exp_read_t entry;
    drive_idle();
    // Reads are modeled first so that they see only earlier writes
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      f = i * NUM_FIELDS + 4 * NUM_WR_PORTS + 3 * p;
      if (op_fields[f][0]) begin
        rd_en[p]   = 1'b1;
        rd_bank[p] = bank_t'(op_fields[f+1]);
        rd_row[p]  = row_t'(op_fields[f+2]);
        entry.due  = n + READ_LATENCY;
        entry.port = p;
        entry.addr = {rd_bank[p], rd_row[p]};
        entry.data = ref_mem[entry.addr];
        exp_q.push_back(entry);
      end
    end
    for (int p = 0; p < NUM_WR_PORTS; p++) begin
      f = i * NUM_FIELDS + 4 * p;
      if (op_fields[f][0]) begin
        wr_en[p]   = 1'b1;
        wr_bank[p] = bank_t'(op_fields[f+1]);
        wr_row[p]  = row_t'(op_fields[f+2]);
        wr_data[p] = word_t'(op_fields[f+3]);
        ref_mem[{wr_bank[p], wr_row[p]}] = wr_data[p];
      end
    end
  endtask

  task automatic check_outputs(input int n);
    logic [NUM_RD_PORTS-1:0] due_vld;
    exp_read_t               due_rd [NUM_RD_PORTS];
    exp_read_t               entry;
    due_vld = '0;
    while (exp_q.size() != 0 && exp_q[0].due == n) begin
      entry = exp_q.pop_front();
      due_rd[entry.port]  = entry;
      due_vld[entry.port] = 1'b1;
    end
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      check_value($sformatf("rd_vld[%0d]", p), 32'(rd_vld[p]), 32'(due_vld[p]));
      if (due_vld[p]) begin
        check_value($sformatf("rd_addr[%0d]", p), 32'(rd_addr[p]), 32'(due_rd[p].addr));
        check_value($sformatf("rd_data[%0d]", p), 32'(rd_data[p]), 32'(due_rd[p].data));
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, the reads did not all come back", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int n;
    rst_n   = 1'b0;
    wr_en   = '0;
    wr_bank = '0;
    wr_row  = '0;
    wr_data = '0;
    rd_en   = '0;
    rd_bank = '0;
    rd_row  = '0;
    void'($urandom(32'ha102));

    for (int j = 0; j < MAX_OPS * NUM_FIELDS; j++) begin
      op_fields[j] = UNUSED;
    end
    $readmemh("bench/banked_mem_input.txt", op_fields);
    num_ops = 0;
    while (num_ops < MAX_OPS && op_fields[num_ops*NUM_FIELDS] != UNUSED) begin
      num_ops++;
    end

    if (num_ops == 0) begin
      error_count++;
      $display("No operations could be read from bench/banked_mem_input.txt");
    end else begin
      timeout_limit = num_ops + READ_LATENCY + RESET_CYCLES + MARGIN;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      n = 0;
      for (int i = 0; i < num_ops; i++) begin
        @(negedge clk);
        check_outputs(n);
        apply_op(i, n);
        n++;
      end
      // Drain the reads still in flight
      while (exp_q.size() != 0) begin
        @(negedge clk);
        check_outputs(n);
        drive_idle();
        n++;
      end
    end

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/banked_mem_input.txt */
// we0 wbank0 wrow0 wdata0  we1 wbank1 wrow1 wdata1  re0 rbank0 rrow0  re1 rbank1 rrow1
// One cycle per line in hex, the other fields of a disabled port are ignored
0 0 0 0000  0 0 0 0000  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  0 0 0  0 0 0
1 0 3 a001  1 4 5 b004  0 0 0  0 0 0
1 1 7 a102  1 5 2 b105  0 0 0  0 0 0
1 2 a a203  1 6 f b206  0 0 0  0 0 0
1 3 0 a304  1 7 9 b307  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  1 0 3  1 4 5
0 0 0 0000  0 0 0 0000  1 1 7  1 5 2
1 2 a c2c2  0 0 0 0000  1 2 a  0 0 0
0 0 0 0000  0 0 0 0000  0 0 0  1 2 a
0 0 0 0000  1 6 f d6d6  0 0 0  1 6 f
0 0 0 0000  0 0 0 0000  1 6 f  0 0 0
0 0 0 0000  0 0 0 0000  1 0 3  1 7 9
0 0 0 0000  0 0 0 0000  1 1 7  1 6 f
0 0 0 0000  0 0 0 0000  1 2 a  1 5 2
0 0 0 0000  0 0 0 0000  1 3 0  1 4 5
0 0 0 0000  0 0 0 0000  1 4 5  1 3 0
0 0 0 0000  0 0 0 0000  1 5 2  1 2 a
0 0 0 0000  0 0 0 0000  1 6 f  1 1 7
0 0 0 0000  0 0 0 0000  1 7 9  1 0 3
1 3 0 e303  1 7 9 e707  1 7 9  1 3 0
0 0 0 0000  0 0 0 0000  1 3 0  1 7 9
1 5 8 1234  1 0 c 5678  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  1 0 c  1 5 8
1 4 0 0f0f  1 1 f f0f0  1 5 8  0 0 0
0 0 0 0000  0 0 0 0000  1 1 f  1 4 0
1 3 6 3636  1 4 6 4646  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  1 4 6  1 3 6
0 0 0 0000  0 0 0 0000  0 0 0  0 0 0
0 0 0 0000  0 0 0 0000  0 0 0  0 0 0

/* list.f */
source/mem_geometry_pkg.sv
source/mem_timing_pkg.sv
source/bank_cmd_if.sv
source/bank_cmd_ctrl.sv
source/write_data_chain.sv
source/bank_ram.sv
source/read_data_chain.sv
source/banked_mem_top.sv
bench/clk_gen.sv
bench/banked_mem_tb.sv

/* Bender.yml */
package:
  name: banked_mem

sources:
  - source/mem_geometry_pkg.sv
  - source/mem_timing_pkg.sv
  - source/bank_cmd_if.sv
  - source/bank_cmd_ctrl.sv
  - source/write_data_chain.sv
  - source/bank_ram.sv
  - source/read_data_chain.sv
  - source/banked_mem_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/banked_mem_tb.sv
